//--- hdl/ad6676_pkg.sv
// *************************************************************************
// shared widths, register map and version of the ad6676 receive core
// imported by every design unit of the core
// *************************************************************************

package ad6676_pkg;

  // data path words
  typedef logic [15:0] sample_t;
  typedef logic [31:0] chan_word_t;
  typedef logic [63:0] lane_word_t;

  // register bus
  typedef logic [13:0] up_addr_t;
  typedef logic [31:0] up_data_t;

  localparam up_data_t CORE_VERSION = 32'h000a0061;

  // word address ranges
  localparam up_addr_t COMMON_BASE  = 14'h0000;
  localparam up_addr_t CHANNEL_BASE = 14'h0100;

  // common offsets
  localparam logic [7:0] REG_VERSION    = 8'h00;
  localparam logic [7:0] REG_ID         = 8'h01;
  localparam logic [7:0] REG_SCRATCH    = 8'h02;
  localparam logic [7:0] REG_RSTN       = 8'h10;
  localparam logic [7:0] REG_STATUS     = 8'h17;
  localparam logic [7:0] REG_DMA_STATUS = 8'h18;

  // channel offsets
  localparam logic [3:0] REG_CHAN_CTRL   = 4'h0;
  localparam logic [3:0] REG_CHAN_STATUS = 4'h1;

endpackage

//--- hdl/up_bus_if.sv
// *************************************************************************
// internal register bus between the axi front end and the register blocks
// ack and rdata carry the merged answer of all slaves
// *************************************************************************

interface up_bus_if import ad6676_pkg::*; ();

  logic     wreq;
  up_addr_t waddr;
  up_data_t wdata;
  logic     wack;
  logic     rreq;
  up_addr_t raddr;
  up_data_t rdata;
  logic     rack;

  modport master (
    output wreq, waddr, wdata, rreq, raddr,
    input  wack, rack, rdata
  );

  // slaves answer on their own wires, merged at the top level
  modport slave (
    input wreq, waddr, wdata, rreq, raddr
  );

endinterface

//--- hdl/ad6676_up_axi.sv
// *************************************************************************
// axi4-lite slave that issues one register bus request per transaction
// requests left without an ack end in SLVERR after UP_TIMEOUT cycles
// *************************************************************************

module ad6676_up_axi import ad6676_pkg::*; #(
  parameter int UP_TIMEOUT = 8
) (
  input  logic        up_clk,
  input  logic        up_rstn,
  input  logic        s_axi_awvalid,
  input  logic [31:0] s_axi_awaddr,
  output logic        s_axi_awready,
  input  logic        s_axi_wvalid,
  input  logic [31:0] s_axi_wdata,
  input  logic [ 3:0] s_axi_wstrb,
  output logic        s_axi_wready,
  output logic        s_axi_bvalid,
  output logic [ 1:0] s_axi_bresp,
  input  logic        s_axi_bready,
  input  logic        s_axi_arvalid,
  input  logic [31:0] s_axi_araddr,
  output logic        s_axi_arready,
  output logic        s_axi_rvalid,
  output logic [ 1:0] s_axi_rresp,
  output logic [31:0] s_axi_rdata,
  input  logic        s_axi_rready,
  up_bus_if.master    bus_m
);

  localparam int TW = $clog2(UP_TIMEOUT) + 1;

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT, ST_RESP} axi_state_t;

  axi_state_t      state;
  logic            is_wr;
  up_addr_t        addr_q;
  up_data_t        wdata_q;
  logic [TW-1:0]   timer;

  assign bus_m.wreq  = (state == ST_REQ) && is_wr;
  assign bus_m.rreq  = (state == ST_REQ) && !is_wr;
  assign bus_m.waddr = addr_q;
  assign bus_m.raddr = addr_q;
  assign bus_m.wdata = wdata_q;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      state         <= ST_IDLE;
      is_wr         <= 1'b0;
      addr_q        <= '0;
      wdata_q       <= '0;
      timer         <= '0;
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      s_axi_arready <= 1'b0;
      s_axi_bvalid  <= 1'b0;
      s_axi_bresp   <= 2'b00;
      s_axi_rvalid  <= 1'b0;
      s_axi_rresp   <= 2'b00;
      s_axi_rdata   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // ready pulses for one cycle, write wins over read
          if (s_axi_awready) begin
            state         <= ST_REQ;
            is_wr         <= 1'b1;
            addr_q        <= s_axi_awaddr[15:2];
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            for (int i = 0; i < 4; i++) begin
              wdata_q[8*i +: 8] <= s_axi_wstrb[i] ? s_axi_wdata[8*i +: 8] : 8'h00;
            end
          end else if (s_axi_arready) begin
            state         <= ST_REQ;
            is_wr         <= 1'b0;
            addr_q        <= s_axi_araddr[15:2];
            s_axi_arready <= 1'b0;
          end else if (s_axi_awvalid && s_axi_wvalid) begin
            s_axi_awready <= 1'b1;
            s_axi_wready  <= 1'b1;
          end else if (s_axi_arvalid) begin
            s_axi_arready <= 1'b1;
          end
        end
        ST_REQ: begin
          state <= ST_WAIT;
          timer <= '0;
        end
        ST_WAIT: begin
          if (is_wr ? bus_m.wack : bus_m.rack) begin
            state        <= ST_RESP;
            s_axi_bvalid <= is_wr;
            s_axi_bresp  <= 2'b00;
            s_axi_rvalid <= !is_wr;
            s_axi_rresp  <= 2'b00;
            s_axi_rdata  <= bus_m.rdata;
          end else if (timer == TW'(UP_TIMEOUT - 1)) begin
            // nobody owns the address
            state        <= ST_RESP;
            s_axi_bvalid <= is_wr;
            s_axi_bresp  <= 2'b10;
            s_axi_rvalid <= !is_wr;
            s_axi_rresp  <= 2'b10;
            s_axi_rdata  <= '0;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        ST_RESP: begin
          if (s_axi_bvalid && s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
            state        <= ST_IDLE;
          end
          if (s_axi_rvalid && s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
            state        <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  a_bvalid_hold: assert property (@(posedge up_clk) disable iff (!up_rstn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

  a_rvalid_hold: assert property (@(posedge up_clk) disable iff (!up_rstn)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid);

  a_one_req: assert property (@(posedge up_clk) disable iff (!up_rstn)
    !(bus_m.wreq && bus_m.rreq));

endmodule

//--- hdl/ad6676_deframer.sv
// *************************************************************************
// registers the 64-bit lane word and reorders its octets into samples
// lane 0 feeds channel 0, lane 1 feeds channel 1
// *************************************************************************

module ad6676_deframer import ad6676_pkg::*; (
  input  logic       up_clk,
  input  logic       up_rstn,
  input  logic       adc_rst,
  input  logic       rx_valid,
  input  lane_word_t rx_data,
  output logic       data_valid,
  output chan_word_t chan_data_0,
  output chan_word_t chan_data_1,
  output logic       link_seen
);

  // octet 0 arrives first and is the high byte of sample 0
  function automatic chan_word_t deframe(input logic [31:0] lane);
    sample_t s0;
    sample_t s1;
    s0 = {lane[ 7: 0], lane[15: 8]};
    s1 = {lane[23:16], lane[31:24]};
    return {s1, s0};
  endfunction

  always_ff @(posedge up_clk) begin
    if (!up_rstn || adc_rst) begin
      data_valid  <= 1'b0;
      chan_data_0 <= '0;
      chan_data_1 <= '0;
    end else begin
      data_valid  <= rx_valid;
      chan_data_0 <= deframe(rx_data[31: 0]);
      chan_data_1 <= deframe(rx_data[63:32]);
    end
  end

  // sticky once the link delivers its first word
  always_ff @(posedge up_clk) begin
    if (!up_rstn || adc_rst) begin
      link_seen <= 1'b0;
    end else if (rx_valid) begin
      link_seen <= 1'b1;
    end
  end

  a_valid_in_rst: assert property (@(posedge up_clk) disable iff (!up_rstn)
    adc_rst |=> !data_valid);

endmodule

//--- hdl/ad6676_channel.sv
// *************************************************************************
// one adc channel: over-range check, ramp monitor and output format
// owns the 16-word register range at CHANNEL_BASE + 0x10 * CHANNEL_ID
// *************************************************************************

module ad6676_channel import ad6676_pkg::*; #(
  parameter int CHANNEL_ID = 0
) (
  input  logic       up_clk,
  input  logic       up_rstn,
  input  logic       adc_rst,
  input  logic       data_valid,
  input  chan_word_t chan_data,
  output logic       adc_valid,
  output logic       adc_enable,
  output chan_word_t adc_data,
  output logic       chan_or,
  output logic       chan_pn_err,
  output logic       chan_pn_oos,
  up_bus_if.slave    bus,
  output logic       wack,
  output logic       rack,
  output up_data_t   rdata
);

  localparam up_addr_t BASE = CHANNEL_BASE + up_addr_t'(CHANNEL_ID * 16);

  typedef enum logic {PN_OOS, PN_SYNC} pn_state_t;

  pn_state_t  pn_state;
  logic [3:0] pn_cnt;
  sample_t    prev;
  sample_t    s0;
  sample_t    s1;
  logic       match;
  logic       or_hit;
  logic       fmt_ob;
  logic       w_sel;
  logic       r_sel;
  logic       w_status;

  assign s0       = chan_data[15:0];
  assign s1       = chan_data[31:16];
  assign match    = (s0 == sample_t'(prev + 1'b1)) && (s1 == sample_t'(s0 + 1'b1));
  assign or_hit   = (s0 == 16'h7fff) || (s0 == 16'h8000) ||
                    (s1 == 16'h7fff) || (s1 == 16'h8000);
  assign w_sel    = bus.wreq && (bus.waddr[13:4] == BASE[13:4]);
  assign r_sel    = bus.rreq && (bus.raddr[13:4] == BASE[13:4]);
  assign w_status = w_sel && (bus.waddr[3:0] == REG_CHAN_STATUS);

  assign chan_pn_oos = (pn_state == PN_OOS);

  // *************************************************************************
  // data path
  // *************************************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn || adc_rst) begin
      adc_valid <= 1'b0;
      adc_data  <= '0;
    end else begin
      adc_valid <= data_valid;
      adc_data  <= fmt_ob ? (chan_data ^ 32'h80008000) : chan_data;
    end
  end

  // ramp monitor, one counter serves both directions
  always_ff @(posedge up_clk) begin
    if (!up_rstn || adc_rst) begin
      pn_state <= PN_OOS;
      pn_cnt   <= '0;
      prev     <= '0;
    end else if (data_valid) begin
      prev <= s1;
      if (pn_state == PN_OOS) begin
        pn_cnt <= match ? pn_cnt + 1'b1 : 4'd0;
        if (match && pn_cnt == 4'd15) begin
          pn_state <= PN_SYNC;
          pn_cnt   <= '0;
        end
      end else begin
        pn_cnt <= match ? 4'd0 : pn_cnt + 1'b1;
        if (!match && pn_cnt == 4'd3) begin
          pn_state <= PN_OOS;
          pn_cnt   <= '0;
        end
      end
    end
  end

  // *************************************************************************
  // registers
  // *************************************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      adc_enable  <= 1'b0;
      fmt_ob      <= 1'b0;
      chan_or     <= 1'b0;
      chan_pn_err <= 1'b0;
      wack        <= 1'b0;
      rack        <= 1'b0;
      rdata       <= '0;
    end else begin
      wack <= w_sel;
      rack <= r_sel;
      if (w_sel && bus.waddr[3:0] == REG_CHAN_CTRL) begin
        adc_enable <= bus.wdata[0];
        fmt_ob     <= bus.wdata[1];
      end
      // set wins over clear
      if (w_status && bus.wdata[0]) chan_or <= 1'b0;
      if (w_status && bus.wdata[1]) chan_pn_err <= 1'b0;
      if (data_valid && or_hit) chan_or <= 1'b1;
      if (data_valid && pn_state == PN_SYNC && !match) chan_pn_err <= 1'b1;
      if (r_sel) begin
        case (bus.raddr[3:0])
          REG_CHAN_CTRL:   rdata <= {30'd0, fmt_ob, adc_enable};
          REG_CHAN_STATUS: rdata <= {29'd0, chan_pn_oos, chan_pn_err, chan_or};
          default:         rdata <= '0;
        endcase
      end else begin
        rdata <= '0;
      end
    end
  end

endmodule

//--- hdl/ad6676_common.sv
// *************************************************************************
// common registers: version, id, scratch, data path reset and status
// answers the whole common range, unused offsets read zero
// *************************************************************************

module ad6676_common import ad6676_pkg::*; #(
  parameter up_data_t ID = 32'h0
) (
  input  logic     up_clk,
  input  logic     up_rstn,
  input  logic     link_seen,
  input  logic     status_or,
  input  logic     status_pn_err,
  input  logic     status_pn_oos,
  input  logic     adc_dovf,
  input  logic     adc_dunf,
  output logic     adc_rst,
  up_bus_if.slave  bus,
  output logic     wack,
  output logic     rack,
  output up_data_t rdata
);

  up_data_t   scratch;
  logic       rstn_q;
  logic [3:0] status_q;
  logic       dma_ovf;
  logic       dma_unf;
  logic       w_sel;
  logic       r_sel;
  logic       w_dma;

  assign w_sel = bus.wreq && (bus.waddr[13:8] == COMMON_BASE[13:8]);
  assign r_sel = bus.rreq && (bus.raddr[13:8] == COMMON_BASE[13:8]);
  assign w_dma = w_sel && (bus.waddr[7:0] == REG_DMA_STATUS);

  // data path stays in reset until software releases it
  assign adc_rst = ~rstn_q;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      scratch  <= '0;
      rstn_q   <= 1'b0;
      status_q <= '0;
      dma_ovf  <= 1'b0;
      dma_unf  <= 1'b0;
      wack     <= 1'b0;
      rack     <= 1'b0;
      rdata    <= '0;
    end else begin
      wack     <= w_sel;
      rack     <= r_sel;
      status_q <= {status_pn_oos, status_pn_err, status_or, link_seen};
      if (w_sel && bus.waddr[7:0] == REG_SCRATCH) scratch <= bus.wdata;
      if (w_sel && bus.waddr[7:0] == REG_RSTN) rstn_q <= bus.wdata[0];
      if (w_dma && bus.wdata[0]) dma_ovf <= 1'b0;
      if (w_dma && bus.wdata[1]) dma_unf <= 1'b0;
      if (adc_dovf) dma_ovf <= 1'b1;
      if (adc_dunf) dma_unf <= 1'b1;
      if (r_sel) begin
        case (bus.raddr[7:0])
          REG_VERSION:    rdata <= CORE_VERSION;
          REG_ID:         rdata <= ID;
          REG_SCRATCH:    rdata <= scratch;
          REG_RSTN:       rdata <= {31'd0, rstn_q};
          REG_STATUS:     rdata <= {28'd0, status_q};
          REG_DMA_STATUS: rdata <= {30'd0, dma_unf, dma_ovf};
          default:        rdata <= '0;
        endcase
      end else begin
        rdata <= '0;
      end
    end
  end

endmodule

//--- hdl/ad6676_core.sv
// *************************************************************************
// top level of the two-channel ad6676 receive core
// lane words in, per-channel sample pairs out, registers over axi4-lite
// *************************************************************************

module ad6676_core import ad6676_pkg::*; #(
  parameter up_data_t ID         = 32'h0,
  parameter int       UP_TIMEOUT = 8
) (
  input  logic        up_clk,
  input  logic        up_rstn,
  input  logic        rx_valid,
  input  lane_word_t  rx_data,
  input  logic        adc_dovf,
  input  logic        adc_dunf,
  output logic        adc_rst,
  output logic        adc_valid_0,
  output logic        adc_valid_1,
  output logic        adc_enable_0,
  output logic        adc_enable_1,
  output chan_word_t  adc_data_0,
  output chan_word_t  adc_data_1,
  input  logic        s_axi_awvalid,
  input  logic [31:0] s_axi_awaddr,
  output logic        s_axi_awready,
  input  logic        s_axi_wvalid,
  input  logic [31:0] s_axi_wdata,
  input  logic [ 3:0] s_axi_wstrb,
  output logic        s_axi_wready,
  output logic        s_axi_bvalid,
  output logic [ 1:0] s_axi_bresp,
  input  logic        s_axi_bready,
  input  logic        s_axi_arvalid,
  input  logic [31:0] s_axi_araddr,
  output logic        s_axi_arready,
  output logic        s_axi_rvalid,
  output logic [ 1:0] s_axi_rresp,
  output logic [31:0] s_axi_rdata,
  input  logic        s_axi_rready
);

  up_bus_if up_bus ();

  logic       data_valid;
  chan_word_t chan_data_0;
  chan_word_t chan_data_1;
  logic       link_seen;
  logic [1:0] chan_or;
  logic [1:0] chan_pn_err;
  logic [1:0] chan_pn_oos;
  logic [2:0] wack_s;
  logic [2:0] rack_s;
  up_data_t   rdata_s [0:2];

  // merge of the slave answers, one register stage
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_bus.wack  <= 1'b0;
      up_bus.rack  <= 1'b0;
      up_bus.rdata <= '0;
    end else begin
      up_bus.wack  <= |wack_s;
      up_bus.rack  <= |rack_s;
      up_bus.rdata <= rdata_s[0] | rdata_s[1] | rdata_s[2];
    end
  end

  ad6676_up_axi #(.UP_TIMEOUT(UP_TIMEOUT)) i_up_axi (
    .up_clk(up_clk), .up_rstn(up_rstn),
    .s_axi_awvalid(s_axi_awvalid), .s_axi_awaddr(s_axi_awaddr),
    .s_axi_awready(s_axi_awready), .s_axi_wvalid(s_axi_wvalid),
    .s_axi_wdata(s_axi_wdata), .s_axi_wstrb(s_axi_wstrb), .s_axi_wready(s_axi_wready),
    .s_axi_bvalid(s_axi_bvalid), .s_axi_bresp(s_axi_bresp), .s_axi_bready(s_axi_bready),
    .s_axi_arvalid(s_axi_arvalid), .s_axi_araddr(s_axi_araddr),
    .s_axi_arready(s_axi_arready), .s_axi_rvalid(s_axi_rvalid),
    .s_axi_rresp(s_axi_rresp), .s_axi_rdata(s_axi_rdata), .s_axi_rready(s_axi_rready),
    .bus_m(up_bus.master));

  ad6676_deframer i_deframer (
    .up_clk(up_clk), .up_rstn(up_rstn), .adc_rst(adc_rst),
    .rx_valid(rx_valid), .rx_data(rx_data), .data_valid(data_valid),
    .chan_data_0(chan_data_0), .chan_data_1(chan_data_1), .link_seen(link_seen));

  ad6676_channel #(.CHANNEL_ID(0)) i_channel_0 (
    .up_clk(up_clk), .up_rstn(up_rstn), .adc_rst(adc_rst),
    .data_valid(data_valid), .chan_data(chan_data_0),
    .adc_valid(adc_valid_0), .adc_enable(adc_enable_0), .adc_data(adc_data_0),
    .chan_or(chan_or[0]), .chan_pn_err(chan_pn_err[0]), .chan_pn_oos(chan_pn_oos[0]),
    .bus(up_bus.slave), .wack(wack_s[0]), .rack(rack_s[0]), .rdata(rdata_s[0]));

  ad6676_channel #(.CHANNEL_ID(1)) i_channel_1 (
    .up_clk(up_clk), .up_rstn(up_rstn), .adc_rst(adc_rst),
    .data_valid(data_valid), .chan_data(chan_data_1),
    .adc_valid(adc_valid_1), .adc_enable(adc_enable_1), .adc_data(adc_data_1),
    .chan_or(chan_or[1]), .chan_pn_err(chan_pn_err[1]), .chan_pn_oos(chan_pn_oos[1]),
    .bus(up_bus.slave), .wack(wack_s[1]), .rack(rack_s[1]), .rdata(rdata_s[1]));

  ad6676_common #(.ID(ID)) i_common (
    .up_clk(up_clk), .up_rstn(up_rstn), .link_seen(link_seen),
    .status_or(|chan_or), .status_pn_err(|chan_pn_err), .status_pn_oos(|chan_pn_oos),
    .adc_dovf(adc_dovf), .adc_dunf(adc_dunf), .adc_rst(adc_rst),
    .bus(up_bus.slave), .wack(wack_s[2]), .rack(rack_s[2]), .rdata(rdata_s[2]));

  // address ranges of the slaves never overlap
  a_single_ack: assert property (@(posedge up_clk) disable iff (!up_rstn)
    $onehot0(wack_s) && $onehot0(rack_s));

endmodule

//--- sim/tb_ad6676.sv
// *************************************************************************
// self-checking testbench of the ad6676 receive core
// axi4-lite register accesses, lane word stimulus and a deframing model
// *************************************************************************

module tb_ad6676 import ad6676_pkg::*; ();

  localparam up_data_t CORE_ID    = 32'h00ad6676;
  localparam up_addr_t ADDR_NONE  = 14'h0200;
  // whole sequence is a few hundred cycles
  localparam int       MAX_CYCLES = 4000;

  logic        up_clk = 1'b0;
  logic        up_rstn;
  logic        rx_valid;
  lane_word_t  rx_data;
  logic        adc_dovf;
  logic        adc_dunf;
  logic        adc_rst;
  logic        adc_valid_0;
  logic        adc_valid_1;
  logic        adc_enable_0;
  logic        adc_enable_1;
  chan_word_t  adc_data_0;
  chan_word_t  adc_data_1;
  logic        s_axi_awvalid;
  logic [31:0] s_axi_awaddr;
  logic        s_axi_awready;
  logic        s_axi_wvalid;
  logic [31:0] s_axi_wdata;
  logic [ 3:0] s_axi_wstrb;
  logic        s_axi_wready;
  logic        s_axi_bvalid;
  logic [ 1:0] s_axi_bresp;
  logic        s_axi_bready;
  logic        s_axi_arvalid;
  logic [31:0] s_axi_araddr;
  logic        s_axi_arready;
  logic        s_axi_rvalid;
  logic [ 1:0] s_axi_rresp;
  logic [31:0] s_axi_rdata;
  logic        s_axi_rready;

  int         seed = 35;
  int         cycles = 0;
  int         n_pass = 0;
  int         n_err = 0;
  int         err_mark = 0;
  logic       ob1 = 1'b0;
  sample_t    ramp0;
  sample_t    ramp1;
  chan_word_t exp0 [$];
  chan_word_t exp1 [$];
  up_data_t   rd;
  logic [1:0] resp;

  ad6676_core #(.ID(CORE_ID), .UP_TIMEOUT(8)) dut0 (.*);

  always #5 up_clk = ~up_clk;

  always @(posedge up_clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  // *************************************************************************
  // reference model and checks
  // *************************************************************************

  // octet 0 is the high byte of sample 0, sample 1 goes to the upper half
  function automatic chan_word_t lane_to_chan(input logic [31:0] lane, input logic ob);
    sample_t smp0;
    sample_t smp1;
    smp0 = {lane[7:0], lane[15:8]};
    smp1 = {lane[23:16], lane[31:24]};
    if (ob) begin
      smp0[15] = ~smp0[15];
      smp1[15] = ~smp1[15];
    end
    return {smp1, smp0};
  endfunction

  function automatic logic [31:0] pack_lane(input sample_t smp0, input sample_t smp1);
    return {smp1[7:0], smp1[15:8], smp0[7:0], smp0[15:8]};
  endfunction

  function automatic up_addr_t chan_addr(input int n, input logic [3:0] off);
    return CHANNEL_BASE + up_addr_t'(16 * n) + up_addr_t'(off);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) begin
      n_pass++;
    end else begin
      n_err++;
      $display("error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    n_err++;
    $display("%s", what);
  endtask

  always @(posedge up_clk) begin
    if (up_rstn && adc_valid_0) begin
      if (exp0.size() == 0) report_failure("adc_valid_0 rose with no word sent");
      else check_value("adc_data_0", adc_data_0, exp0.pop_front());
    end
    if (up_rstn && adc_valid_1) begin
      if (exp1.size() == 0) report_failure("adc_valid_1 rose with no word sent");
      else check_value("adc_data_1", adc_data_1, exp1.pop_front());
    end
  end

  a_no_valid_in_rst: assert property (@(posedge up_clk) disable iff (!up_rstn)
    adc_rst |-> !adc_valid_0 && !adc_valid_1)
    else report_failure("adc_valid is high while adc_rst is set");

  a_latency: assert property (@(posedge up_clk) disable iff (!up_rstn || adc_rst)
    adc_valid_0 == $past(rx_valid, 2) && adc_valid_1 == $past(rx_valid, 2))
    else report_failure("adc_valid does not follow rx_valid by two cycles");

  a_ready_pair: assert property (@(posedge up_clk) disable iff (!up_rstn)
    s_axi_awready == s_axi_wready)
    else report_failure("awready and wready do not pulse together");

  // *************************************************************************
  // bus and link tasks
  // *************************************************************************

  task automatic axi_write(input up_addr_t addr, input up_data_t data,
                           output logic [1:0] bresp);
    s_axi_awaddr  = {16'd0, addr, 2'b00};
    s_axi_wdata   = data;
    s_axi_wstrb   = 4'hf;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    do begin
      @(posedge up_clk);
    end while (!s_axi_awready);
    #1;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    do begin
      @(posedge up_clk);
    end while (!s_axi_bvalid);
    bresp = s_axi_bresp;
    // response waits one cycle before it is taken
    #1;
    s_axi_bready = 1'b1;
    @(posedge up_clk);
    #1;
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input up_addr_t addr, output up_data_t data,
                          output logic [1:0] rresp);
    s_axi_araddr  = {16'd0, addr, 2'b00};
    s_axi_arvalid = 1'b1;
    do begin
      @(posedge up_clk);
    end while (!s_axi_arready);
    #1;
    s_axi_arvalid = 1'b0;
    do begin
      @(posedge up_clk);
    end while (!s_axi_rvalid);
    data  = s_axi_rdata;
    rresp = s_axi_rresp;
    #1;
    s_axi_rready = 1'b1;
    @(posedge up_clk);
    #1;
    s_axi_rready = 1'b0;
  endtask

  task automatic reg_write(input up_addr_t addr, input up_data_t data);
    logic [1:0] bresp;
    axi_write(addr, data, bresp);
    check_value("s_axi_bresp", bresp, 2'b00);
  endtask

  task automatic read_check(input up_addr_t addr, input up_data_t mask,
                            input up_data_t exp, input string name);
    up_data_t   data;
    logic [1:0] rresp;
    axi_read(addr, data, rresp);
    check_value("s_axi_rresp", rresp, 2'b00);
    check_value(name, data & mask, exp);
  endtask

  task automatic send_word(input lane_word_t w);
    rx_valid = 1'b1;
    rx_data  = w;
    if (!adc_rst) begin
      exp0.push_back(lane_to_chan(w[31:0], 1'b0));
      exp1.push_back(lane_to_chan(w[63:32], ob1));
    end
    @(posedge up_clk);
    #1;
  endtask

  task automatic send_random(input int n);
    repeat (n) send_word({$random(seed), $random(seed)});
  endtask

  task automatic send_ramp(input int n);
    repeat (n) begin
      send_word({pack_lane(ramp1, ramp1 + 1'b1), pack_lane(ramp0, ramp0 + 1'b1)});
      ramp0 = ramp0 + 2'd2;
      ramp1 = ramp1 + 2'd2;
    end
  endtask

  task automatic idle_link();
    rx_valid = 1'b0;
    repeat (3) @(posedge up_clk);
    #1;
    if (exp0.size() != 0 || exp1.size() != 0)
      report_failure("sent lane words never reached adc_data");
  endtask

  task automatic end_test(input string name);
    if (n_err == err_mark) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, n_err - err_mark);
    err_mark = n_err;
  endtask

  // *************************************************************************
  // sequence
  // *************************************************************************

  initial begin
    up_rstn       = 1'b0;
    rx_valid      = 1'b0;
    rx_data       = '0;
    adc_dovf      = 1'b0;
    adc_dunf      = 1'b0;
    s_axi_awvalid = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_bready  = 1'b0;
    s_axi_arvalid = 1'b0;
    s_axi_araddr  = '0;
    s_axi_rready  = 1'b0;
    repeat (2) @(posedge up_clk);
    #1;
    up_rstn = 1'b1;

    read_check(COMMON_BASE + REG_VERSION, '1, CORE_VERSION, "version");
    read_check(COMMON_BASE + REG_ID, '1, CORE_ID, "id");
    reg_write(COMMON_BASE + REG_SCRATCH, 32'h5aa5c33c);
    read_check(COMMON_BASE + REG_SCRATCH, '1, 32'h5aa5c33c, "scratch");
    end_test("register access");

    axi_read(ADDR_NONE, rd, resp);
    check_value("s_axi_rresp", resp, 2'b10);
    check_value("s_axi_rdata", rd, 32'h0);
    axi_write(ADDR_NONE, 32'hffffffff, resp);
    check_value("s_axi_bresp", resp, 2'b10);
    end_test("unmapped address");

    // words while the data path is held in reset are dropped
    check_value("adc_rst", adc_rst, 1'b1);
    send_random(4);
    idle_link();
    reg_write(COMMON_BASE + REG_RSTN, 32'h1);
    check_value("adc_rst", adc_rst, 1'b0);
    reg_write(chan_addr(0, REG_CHAN_CTRL), 32'h1);
    reg_write(chan_addr(1, REG_CHAN_CTRL), 32'h1);
    check_value("adc_enable_0", adc_enable_0, 1'b1);
    check_value("adc_enable_1", adc_enable_1, 1'b1);
    send_random(32);
    idle_link();
    reg_write(chan_addr(1, REG_CHAN_CTRL), 32'h3);
    ob1 = 1'b1;
    read_check(chan_addr(1, REG_CHAN_CTRL), '1, 32'h3, "chan1_ctrl");
    send_random(32);
    idle_link();
    end_test("data path");

    reg_write(chan_addr(0, REG_CHAN_STATUS), 32'h3);
    reg_write(chan_addr(1, REG_CHAN_STATUS), 32'h3);
    read_check(chan_addr(1, REG_CHAN_STATUS), 32'h1, 32'h0, "chan1_status");
    send_word({pack_lane(16'h0200, 16'h0300), pack_lane(16'h7fff, 16'h0100)});
    idle_link();
    read_check(chan_addr(0, REG_CHAN_STATUS), 32'h1, 32'h1, "chan0_status");
    read_check(COMMON_BASE + REG_STATUS, 32'h2, 32'h2, "common_status");
    reg_write(chan_addr(0, REG_CHAN_STATUS), 32'h1);
    read_check(chan_addr(0, REG_CHAN_STATUS), 32'h1, 32'h0, "chan0_status");
    read_check(chan_addr(1, REG_CHAN_STATUS), 32'h1, 32'h0, "chan1_status");
    end_test("over-range");

    reg_write(chan_addr(0, REG_CHAN_STATUS), 32'h3);
    reg_write(chan_addr(1, REG_CHAN_STATUS), 32'h3);
    ramp0 = 16'h1000;
    ramp1 = 16'h2000;
    send_ramp(20);
    idle_link();
    read_check(chan_addr(0, REG_CHAN_STATUS), 32'h7, 32'h0, "chan0_status");
    read_check(chan_addr(1, REG_CHAN_STATUS), 32'h7, 32'h0, "chan1_status");
    // one bad sample on channel 0 only
    send_ramp(2);
    send_word({pack_lane(ramp1, ramp1 + 1'b1), pack_lane(16'h0bad, ramp0 + 1'b1)});
    ramp0 = ramp0 + 2'd2;
    ramp1 = ramp1 + 2'd2;
    send_ramp(3);
    idle_link();
    read_check(chan_addr(0, REG_CHAN_STATUS), 32'h7, 32'h2, "chan0_status");
    read_check(chan_addr(1, REG_CHAN_STATUS), 32'h7, 32'h0, "chan1_status");
    send_random(6);
    idle_link();
    read_check(chan_addr(0, REG_CHAN_STATUS), 32'h4, 32'h4, "chan0_status");
    read_check(chan_addr(1, REG_CHAN_STATUS), 32'h4, 32'h4, "chan1_status");
    read_check(COMMON_BASE + REG_STATUS, 32'h9, 32'h9, "common_status");
    end_test("ramp monitor");

    adc_dovf = 1'b1;
    @(posedge up_clk);
    #1;
    adc_dovf = 1'b0;
    read_check(COMMON_BASE + REG_DMA_STATUS, 32'h3, 32'h1, "dma_status");
    adc_dunf = 1'b1;
    @(posedge up_clk);
    #1;
    adc_dunf = 1'b0;
    read_check(COMMON_BASE + REG_DMA_STATUS, 32'h3, 32'h3, "dma_status");
    reg_write(COMMON_BASE + REG_DMA_STATUS, 32'h1);
    read_check(COMMON_BASE + REG_DMA_STATUS, 32'h3, 32'h2, "dma_status");
    reg_write(COMMON_BASE + REG_DMA_STATUS, 32'h2);
    read_check(COMMON_BASE + REG_DMA_STATUS, 32'h3, 32'h0, "dma_status");
    end_test("dma status");

    $display("checks passed: %0d, errors: %0d", n_pass, n_err);
    if (n_err == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- ad6676_core.f
hdl/ad6676_pkg.sv
hdl/up_bus_if.sv
hdl/ad6676_up_axi.sv
hdl/ad6676_deframer.sv
hdl/ad6676_channel.sv
hdl/ad6676_common.sv
hdl/ad6676_core.sv
sim/tb_ad6676.sv

//--- Bender.yml
package:
  name: ad6676_core

sources:
  - hdl/ad6676_pkg.sv
  - hdl/up_bus_if.sv
  - hdl/ad6676_up_axi.sv
  - hdl/ad6676_deframer.sv
  - hdl/ad6676_channel.sv
  - hdl/ad6676_common.sv
  - hdl/ad6676_core.sv
  - target: test
    files:
      - sim/tb_ad6676.sv
